// ==== src/br_cfg.svh ====
`ifndef BR_CFG_SVH
`define BR_CFG_SVH

// datapath width for pc, operands and immediates
`define BR_XLEN 32

// fall-through step between sequential instructions
`define BR_INSN_BYTES 4

// lanes issued to the execute stage per cycle
`define BR_LANES 2

`endif

// ==== src/br_pkg.sv ====
`default_nettype none

package br_pkg;

    // branch kind as decoded, BR_NONE marks a non-branch slot
    typedef enum logic [3:0] {
        BR_NONE = 4'd0,     // plain instruction
        BR_BEQ  = 4'd1,     // rdata1 == rdata2
        BR_BNE  = 4'd2,     // rdata1 != rdata2
        BR_BLT  = 4'd3,     // signed less than
        BR_BGE  = 4'd4,     // signed greater or equal
        BR_BLTU = 4'd5,     // unsigned less than
        BR_BGEU = 4'd6,     // unsigned greater or equal
        BR_B    = 4'd7,     // pc relative jump
        BR_BL   = 4'd8,     // pc relative call
        BR_JIRL = 4'd9      // register indirect jump
    } br_type_e;

    // predictor class of a branch
    // supplied by the decoder and passed to the predictor untouched
    typedef enum logic [1:0] {
        PD_NONE    = 2'd0,  // no predictor entry
        PD_COND    = 2'd1,  // conditional direction
        PD_CALL    = 2'd2,  // call pushes ras
        PD_RET_IND = 2'd3   // return or indirect
    } pd_type_e;

endpackage

`default_nettype wire

// ==== src/br_lane_if.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

interface br_lane_if
    import br_pkg::*;
();

    logic                   valid;      // lane holds a live instruction
    logic [`BR_XLEN-1:0]    pc;         // instruction address
    logic [`BR_XLEN-1:0]    rdata1;     // first source register
    logic [`BR_XLEN-1:0]    rdata2;     // second source register
    logic [`BR_XLEN-1:0]    imm;        // sign extended offset
    br_type_e               br_type;    // branch kind
    logic                   pd_taken;   // front end direction guess
    logic [`BR_XLEN-1:0]    pd_target;  // front end next pc guess
    pd_type_e               pd_type;    // predictor class

    // stage register side
    modport src (
        output valid,
        output pc,
        output rdata1,
        output rdata2,
        output imm,
        output br_type,
        output pd_taken,
        output pd_target,
        output pd_type
    );

    // resolver side
    modport dst (
        input valid,
        input pc,
        input rdata1,
        input rdata2,
        input imm,
        input br_type,
        input pd_taken,
        input pd_target,
        input pd_type
    );

endinterface

`default_nettype wire

// ==== src/branch_eval.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module branch_eval
    import br_pkg::*;
(
    input  br_type_e                br_type,    // branch kind of this lane
    input  logic [`BR_XLEN-1:0]     pc,         // lane pc
    input  logic [`BR_XLEN-1:0]     rdata1,     // first operand
    input  logic [`BR_XLEN-1:0]     rdata2,     // second operand
    input  logic [`BR_XLEN-1:0]     imm,        // offset
    output logic                    taken,      // true direction
    output logic [`BR_XLEN-1:0]     target,     // true next pc
    output logic [`BR_XLEN-1:0]     jump_addr   // raw jump address, taken or not
);

    localparam logic [`BR_XLEN-1:0] INSN_STEP = `BR_INSN_BYTES;

    logic                   eq;         // operands equal
    logic                   lt_s;       // signed less than
    logic                   lt_u;       // unsigned less than
    logic [`BR_XLEN-1:0]    base;       // jump base
    logic [`BR_XLEN-1:0]    fall_pc;    // sequential next pc

    assign eq   = (rdata1 == rdata2);
    assign lt_s = ($signed(rdata1) < $signed(rdata2));
    assign lt_u = (rdata1 < rdata2);

    // jirl jumps off the register, everything else off pc
    assign base      = (br_type == BR_JIRL) ? rdata1 : pc;
    assign jump_addr = base + imm;
    assign fall_pc   = pc + INSN_STEP;

    always_comb begin
        case (br_type)
            BR_BEQ:  taken = eq;
            BR_BNE:  taken = !eq;
            BR_BLT:  taken = lt_s;
            BR_BGE:  taken = !lt_s;
            BR_BLTU: taken = lt_u;
            BR_BGEU: taken = !lt_u;
            BR_B,
            BR_BL,
            BR_JIRL: taken = 1'b1;       // unconditional
            default: taken = 1'b0;       // BR_NONE and unused codes
        endcase
    end

    // not taken resolves to the next sequential instruction
    assign target = taken ? jump_addr : fall_pc;

endmodule

`default_nettype wire

// ==== src/branch_resolve.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module branch_resolve
    import br_pkg::*;
(
    br_lane_if.dst                  lane_a,         // older lane
    br_lane_if.dst                  lane_b,         // younger lane
    output logic                    mispredict_a,   // lane a caused the redirect
    output logic                    redirect_req,   // fetch must be corrected
    output logic [`BR_XLEN-1:0]     redirect_pc,    // corrected fetch pc
    output logic                    upd_req,        // predictor training valid
    output logic [`BR_XLEN-1:0]     upd_pc,         // pc of trained branch
    output pd_type_e                upd_type,       // class of trained branch
    output logic [`BR_XLEN-1:0]     upd_target,     // jump address for btb
    output logic                    upd_taken       // true direction
);

    logic                   taken_a;
    logic                   taken_b;
    logic [`BR_XLEN-1:0]    target_a;
    logic [`BR_XLEN-1:0]    target_b;
    logic [`BR_XLEN-1:0]    jump_a;
    logic [`BR_XLEN-1:0]    jump_b;
    logic                   is_br_a;        // live branch in lane a
    logic                   is_br_b;        // live branch in lane b
    logic                   mis_b;          // lane b wrong guess after wrong path filter
    logic                   b_wrong_path;   // lane a jumps away from lane b
    logic                   upd_sel_b;      // train on lane b

    branch_eval eval_a (
        .br_type   (lane_a.br_type),
        .pc        (lane_a.pc),
        .rdata1    (lane_a.rdata1),
        .rdata2    (lane_a.rdata2),
        .imm       (lane_a.imm),
        .taken     (taken_a),
        .target    (target_a),
        .jump_addr (jump_a)
    );

    branch_eval eval_b (
        .br_type   (lane_b.br_type),
        .pc        (lane_b.pc),
        .rdata1    (lane_b.rdata1),
        .rdata2    (lane_b.rdata2),
        .imm       (lane_b.imm),
        .taken     (taken_b),
        .target    (target_b),
        .jump_addr (jump_b)
    );

    assign is_br_a = lane_a.valid && (lane_a.br_type != BR_NONE);
    assign is_br_b = lane_b.valid && (lane_b.br_type != BR_NONE);

    // direction or target mismatch, fall-through target compared too
    assign mispredict_a = is_br_a &&
                          ((lane_a.pd_taken != taken_a) || (lane_a.pd_target != target_a));

    assign b_wrong_path = is_br_a && taken_a;   // lane b never executes
    assign mis_b        = is_br_b && !b_wrong_path &&
                          ((lane_b.pd_taken != taken_b) || (lane_b.pd_target != target_b));

    assign redirect_req = mispredict_a || mis_b;
    assign redirect_pc  = mispredict_a ? target_a : target_b;   // older lane wins

    // lane a trains whenever it carries a predictor class
    assign upd_sel_b  = (lane_a.pd_type == PD_NONE);
    assign upd_req    = upd_sel_b ? (lane_b.valid && (lane_b.pd_type != PD_NONE))
                                  : lane_a.valid;
    assign upd_pc     = upd_sel_b ? lane_b.pc      : lane_a.pc;
    assign upd_type   = upd_sel_b ? lane_b.pd_type : lane_a.pd_type;
    assign upd_target = upd_sel_b ? jump_b         : jump_a;
    assign upd_taken  = upd_sel_b ? taken_b        : taken_a;

endmodule

`default_nettype wire

// ==== src/ex_issue_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module ex_issue_reg
    import br_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,      // hold current pair
    input  logic                    flush,      // drop wrong path pair
    input  logic                    a_valid,
    input  logic [`BR_XLEN-1:0]     a_pc,
    input  logic [`BR_XLEN-1:0]     a_rdata1,
    input  logic [`BR_XLEN-1:0]     a_rdata2,
    input  logic [`BR_XLEN-1:0]     a_imm,
    input  br_type_e                a_br_type,
    input  logic                    a_pd_taken,
    input  logic [`BR_XLEN-1:0]     a_pd_target,
    input  pd_type_e                a_pd_type,
    input  logic                    b_valid,
    input  logic [`BR_XLEN-1:0]     b_pc,
    input  logic [`BR_XLEN-1:0]     b_rdata1,
    input  logic [`BR_XLEN-1:0]     b_rdata2,
    input  logic [`BR_XLEN-1:0]     b_imm,
    input  br_type_e                b_br_type,
    input  logic                    b_pd_taken,
    input  logic [`BR_XLEN-1:0]     b_pd_target,
    input  pd_type_e                b_pd_type,
    br_lane_if.src                  ex_a,       // older lane to resolver
    br_lane_if.src                  ex_b        // younger lane to resolver
);

    // valid bits, flush beats stall
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ex_a.valid <= 1'b0;
            ex_b.valid <= 1'b0;
        end else if (!stall) begin
            ex_a.valid <= a_valid;
            ex_b.valid <= b_valid;
        end
    end

    // payload only moves with the pipe
    always_ff @(posedge clk) begin
        if (!stall) begin
            ex_a.pc        <= a_pc;
            ex_a.rdata1    <= a_rdata1;
            ex_a.rdata2    <= a_rdata2;
            ex_a.imm       <= a_imm;
            ex_a.br_type   <= a_br_type;
            ex_a.pd_taken  <= a_pd_taken;
            ex_a.pd_target <= a_pd_target;
            ex_a.pd_type   <= a_pd_type;
            ex_b.pc        <= b_pc;
            ex_b.rdata1    <= b_rdata1;
            ex_b.rdata2    <= b_rdata2;
            ex_b.imm       <= b_imm;
            ex_b.br_type   <= b_br_type;
            ex_b.pd_taken  <= b_pd_taken;
            ex_b.pd_target <= b_pd_target;
            ex_b.pd_type   <= b_pd_type;
        end
    end

endmodule

`default_nettype wire

// ==== src/redirect_reg.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module redirect_reg
    import br_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    mispredict_a,   // from resolver
    input  logic                    redirect_req,
    input  logic [`BR_XLEN-1:0]     redirect_pc_d,
    input  logic                    upd_req,
    input  logic [`BR_XLEN-1:0]     upd_pc_d,
    input  pd_type_e                upd_type_d,
    input  logic [`BR_XLEN-1:0]     upd_target_d,
    input  logic                    upd_taken_d,
    output logic                    redirect,       // one cycle pulse to fetch
    output logic [`BR_XLEN-1:0]     redirect_pc,
    output logic                    mispredict_a_q, // redirect came from lane a
    output logic                    upd_valid,      // one cycle pulse to predictor
    output logic [`BR_XLEN-1:0]     upd_pc,
    output pd_type_e                upd_type,
    output logic [`BR_XLEN-1:0]     upd_target,
    output logic                    upd_taken
);

    // pair resolving while redirect is high is already wrong path
    always_ff @(posedge clk) begin
        if (rst || stall) begin
            redirect       <= 1'b0;
            mispredict_a_q <= 1'b0;
            upd_valid      <= 1'b0;
        end else begin
            redirect       <= redirect_req && !redirect;
            mispredict_a_q <= mispredict_a && !redirect;
            upd_valid      <= upd_req && !redirect;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            redirect_pc <= redirect_pc_d;
            upd_pc      <= upd_pc_d;
            upd_type    <= upd_type_d;
            upd_target  <= upd_target_d;
            upd_taken   <= upd_taken_d;
        end
    end

endmodule

`default_nettype wire

// ==== src/br_unit_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module br_unit_top
    import br_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    input  logic                    a_valid,
    input  logic [`BR_XLEN-1:0]     a_pc,
    input  logic [`BR_XLEN-1:0]     a_rdata1,
    input  logic [`BR_XLEN-1:0]     a_rdata2,
    input  logic [`BR_XLEN-1:0]     a_imm,
    input  br_type_e                a_br_type,
    input  logic                    a_pd_taken,
    input  logic [`BR_XLEN-1:0]     a_pd_target,
    input  pd_type_e                a_pd_type,
    input  logic                    b_valid,
    input  logic [`BR_XLEN-1:0]     b_pc,
    input  logic [`BR_XLEN-1:0]     b_rdata1,
    input  logic [`BR_XLEN-1:0]     b_rdata2,
    input  logic [`BR_XLEN-1:0]     b_imm,
    input  br_type_e                b_br_type,
    input  logic                    b_pd_taken,
    input  logic [`BR_XLEN-1:0]     b_pd_target,
    input  pd_type_e                b_pd_type,
    output logic                    redirect,
    output logic [`BR_XLEN-1:0]     redirect_pc,
    output logic                    redirect_from_a,
    output logic                    upd_valid,
    output logic [`BR_XLEN-1:0]     upd_pc,
    output pd_type_e                upd_type,
    output logic [`BR_XLEN-1:0]     upd_target,
    output logic                    upd_taken
);

    br_lane_if ex_a ();     // issued older lane
    br_lane_if ex_b ();     // issued younger lane

    logic                   res_mis_a;
    logic                   res_redirect;
    logic [`BR_XLEN-1:0]    res_redirect_pc;
    logic                   res_upd;
    logic [`BR_XLEN-1:0]    res_upd_pc;
    pd_type_e               res_upd_type;
    logic [`BR_XLEN-1:0]    res_upd_target;
    logic                   res_upd_taken;

    ex_issue_reg issue0 (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .flush       (redirect),    // kill pair behind a redirect
        .a_valid     (a_valid),
        .a_pc        (a_pc),
        .a_rdata1    (a_rdata1),
        .a_rdata2    (a_rdata2),
        .a_imm       (a_imm),
        .a_br_type   (a_br_type),
        .a_pd_taken  (a_pd_taken),
        .a_pd_target (a_pd_target),
        .a_pd_type   (a_pd_type),
        .b_valid     (b_valid),
        .b_pc        (b_pc),
        .b_rdata1    (b_rdata1),
        .b_rdata2    (b_rdata2),
        .b_imm       (b_imm),
        .b_br_type   (b_br_type),
        .b_pd_taken  (b_pd_taken),
        .b_pd_target (b_pd_target),
        .b_pd_type   (b_pd_type),
        .ex_a        (ex_a),
        .ex_b        (ex_b)
    );

    branch_resolve resolve0 (
        .lane_a       (ex_a),
        .lane_b       (ex_b),
        .mispredict_a (res_mis_a),
        .redirect_req (res_redirect),
        .redirect_pc  (res_redirect_pc),
        .upd_req      (res_upd),
        .upd_pc       (res_upd_pc),
        .upd_type     (res_upd_type),
        .upd_target   (res_upd_target),
        .upd_taken    (res_upd_taken)
    );

    redirect_reg out0 (
        .clk            (clk),
        .rst            (rst),
        .stall          (stall),
        .mispredict_a   (res_mis_a),
        .redirect_req   (res_redirect),
        .redirect_pc_d  (res_redirect_pc),
        .upd_req        (res_upd),
        .upd_pc_d       (res_upd_pc),
        .upd_type_d     (res_upd_type),
        .upd_target_d   (res_upd_target),
        .upd_taken_d    (res_upd_taken),
        .redirect       (redirect),
        .redirect_pc    (redirect_pc),
        .mispredict_a_q (redirect_from_a),
        .upd_valid      (upd_valid),
        .upd_pc         (upd_pc),
        .upd_type       (upd_type),
        .upd_target     (upd_target),
        .upd_taken      (upd_taken)
    );

endmodule

`default_nettype wire

// ==== test/tb_br_model.svh ====
`ifndef TB_BR_MODEL_SVH
`define TB_BR_MODEL_SVH

// one issued lane as driven on the top ports
typedef struct packed {
    logic                   valid;
    logic [`BR_XLEN-1:0]    pc;
    logic [`BR_XLEN-1:0]    rdata1;
    logic [`BR_XLEN-1:0]    rdata2;
    logic [`BR_XLEN-1:0]    imm;
    br_type_e               br_type;
    logic                   pd_taken;
    logic [`BR_XLEN-1:0]    pd_target;
    pd_type_e               pd_type;
} lane_t;

// registered outputs two edges after issue
typedef struct packed {
    logic                   redirect;
    logic [`BR_XLEN-1:0]    redirect_pc;
    logic                   from_a;
    logic                   upd_valid;
    logic [`BR_XLEN-1:0]    upd_pc;
    pd_type_e               upd_type;
    logic [`BR_XLEN-1:0]    upd_target;
    logic                   upd_taken;
} expect_t;

function automatic logic is_branch(input lane_t l);
    return l.valid && (l.br_type != BR_NONE);
endfunction

function automatic logic true_taken(input lane_t l);
    logic t;
    case (l.br_type)
        BR_BEQ:  t = (l.rdata1 == l.rdata2);
        BR_BNE:  t = (l.rdata1 != l.rdata2);
        BR_BLT:  t = ($signed(l.rdata1) < $signed(l.rdata2));
        BR_BGE:  t = ($signed(l.rdata1) >= $signed(l.rdata2));
        BR_BLTU: t = (l.rdata1 < l.rdata2);        // unsigned
        BR_BGEU: t = (l.rdata1 >= l.rdata2);
        BR_B, BR_BL, BR_JIRL: t = 1'b1;            // always jump
        default: t = 1'b0;
    endcase
    return t;
endfunction

// jump address whether taken or not
function automatic logic [`BR_XLEN-1:0] jump_dest(input lane_t l);
    return (l.br_type == BR_JIRL) ? l.rdata1 + l.imm : l.pc + l.imm;
endfunction

function automatic logic [`BR_XLEN-1:0] true_target(input lane_t l);
    return true_taken(l) ? jump_dest(l) : l.pc + `BR_INSN_BYTES;   // fall-through
endfunction

// wrong direction or wrong target
function automatic logic mispredicts(input lane_t l);
    return is_branch(l) &&
           ((l.pd_taken != true_taken(l)) || (l.pd_target != true_target(l)));
endfunction

function automatic expect_t expected_outputs(input lane_t la, input lane_t lb);
    expect_t e;
    lane_t   u;
    logic    mis_a;
    logic    mis_b;
    mis_a = mispredicts(la);
    mis_b = mispredicts(lb) && !(is_branch(la) && true_taken(la));  // b behind taken a
    e.redirect    = mis_a || mis_b;
    e.redirect_pc = mis_a ? true_target(la) : true_target(lb);     // older lane first
    e.from_a      = mis_a;
    u = (la.pd_type != PD_NONE) ? la : lb;                          // training lane
    e.upd_valid   = u.valid && (u.pd_type != PD_NONE);
    e.upd_pc      = u.pc;
    e.upd_type    = u.pd_type;
    e.upd_target  = jump_dest(u);
    e.upd_taken   = true_taken(u);
    return e;
endfunction

`endif

// ==== test/tb_br_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "br_cfg.svh"

module tb_br_unit
    import br_pkg::*;
();

`include "tb_br_model.svh"

    localparam lane_t idle_lane = '0;  // valid low, BR_NONE, PD_NONE

    logic                   clk;
    logic                   rst;
    logic                   stall;
    lane_t                  lane_a_in;     // older lane ports
    lane_t                  lane_b_in;     // younger lane ports
    logic                   redirect;
    logic [`BR_XLEN-1:0]    redirect_pc;
    logic                   redirect_from_a;
    logic                   upd_valid;
    logic [`BR_XLEN-1:0]    upd_pc;
    pd_type_e               upd_type;
    logic [`BR_XLEN-1:0]    upd_target;
    logic                   upd_taken;
    logic [31:0]            lfsr_state = 32'h38f6;

    br_unit_top dut0 (
        .clk             (clk),
        .rst             (rst),
        .stall           (stall),
        .a_valid         (lane_a_in.valid),
        .a_pc            (lane_a_in.pc),
        .a_rdata1        (lane_a_in.rdata1),
        .a_rdata2        (lane_a_in.rdata2),
        .a_imm           (lane_a_in.imm),
        .a_br_type       (lane_a_in.br_type),
        .a_pd_taken      (lane_a_in.pd_taken),
        .a_pd_target     (lane_a_in.pd_target),
        .a_pd_type       (lane_a_in.pd_type),
        .b_valid         (lane_b_in.valid),
        .b_pc            (lane_b_in.pc),
        .b_rdata1        (lane_b_in.rdata1),
        .b_rdata2        (lane_b_in.rdata2),
        .b_imm           (lane_b_in.imm),
        .b_br_type       (lane_b_in.br_type),
        .b_pd_taken      (lane_b_in.pd_taken),
        .b_pd_target     (lane_b_in.pd_target),
        .b_pd_type       (lane_b_in.pd_type),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc),
        .redirect_from_a (redirect_from_a),
        .upd_valid       (upd_valid),
        .upd_pc          (upd_pc),
        .upd_type        (upd_type),
        .upd_target      (upd_target),
        .upd_taken       (upd_taken)
    );

    always #50 clk = ~clk;     // 100 ns period

    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int nbits);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < nbits; i++) begin
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic logic [`BR_XLEN-1:0] rand_pc();
        return rand_bits(30) << 2;     // word aligned
    endfunction

    function automatic logic [`BR_XLEN-1:0] rand_imm();
        logic [31:0] x;
        x = rand_bits(16);
        return {{14{x[15]}}, x[15:0], 2'b00};  // signed 18-bit offset
    endfunction

    function automatic lane_t make_lane(input logic v, input logic [`BR_XLEN-1:0] pc,
                                        input logic [`BR_XLEN-1:0] r1,
                                        input logic [`BR_XLEN-1:0] r2,
                                        input logic [`BR_XLEN-1:0] imm, input br_type_e t,
                                        input logic pt, input logic [`BR_XLEN-1:0] ptgt,
                                        input pd_type_e pdt);
        lane_t l;
        l.valid     = v;
        l.pc        = pc;
        l.rdata1    = r1;
        l.rdata2    = r2;
        l.imm       = imm;
        l.br_type   = t;
        l.pd_taken  = pt;
        l.pd_target = ptgt;
        l.pd_type   = pdt;
        return l;
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_bit(input string test, input string field, input logic exp,
                             input logic act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s %s: expected %0b, actual %0b",
                                     test, field, exp, act));
    endtask

    task automatic check_pc(input string test, input string field,
                            input logic [`BR_XLEN-1:0] exp, input logic [`BR_XLEN-1:0] act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s %s: expected %h, actual %h",
                                     test, field, exp, act));
    endtask

    task automatic check_pd_type(input string test, input string field, input pd_type_e exp,
                                 input pd_type_e act);
        if (act !== exp)
            report_failure($sformatf("Mismatch %s %s: expected %s, actual %s",
                                     test, field, exp.name(), act.name()));
    endtask

    task automatic check_outputs(input string test, input expect_t e);
        check_bit(test, "redirect", e.redirect, redirect);
        check_bit(test, "redirect_from_a", e.from_a, redirect_from_a);
        if (e.redirect)
            check_pc(test, "redirect_pc", e.redirect_pc, redirect_pc);
        check_bit(test, "upd_valid", e.upd_valid, upd_valid);
        if (e.upd_valid) begin
            check_pc(test, "upd_pc", e.upd_pc, upd_pc);
            check_pd_type(test, "upd_type", e.upd_type, upd_type);
            check_pc(test, "upd_target", e.upd_target, upd_target);
            check_bit(test, "upd_taken", e.upd_taken, upd_taken);
        end
    endtask

    task automatic check_quiet(input string test);
        check_bit(test, "redirect", 1'b0, redirect);
        check_bit(test, "upd_valid", 1'b0, upd_valid);
    endtask

    task automatic drive_pair(input lane_t la, input lane_t lb);
        @(posedge clk);
        lane_a_in <= la;
        lane_b_in <= lb;
    endtask

    // returns at the negedge where either pulse is seen
    task automatic wait_pulse(input string test, input int max_cycles);
        int n;
        n = 0;
        @(negedge clk);
        while (!(redirect === 1'b1 || upd_valid === 1'b1)) begin
            if (n == max_cycles)
                report_failure($sformatf("%s saw no redirect or update pulse within %0d cycles",
                                         test, max_cycles));
            @(negedge clk);
            n++;
        end
    endtask

    // one pair with outputs checked exactly two edges after issue
    task automatic run_pair(input string test, input lane_t la, input lane_t lb);
        expect_t e;
        e = expected_outputs(la, lb);
        drive_pair(la, lb);
        drive_pair(idle_lane, idle_lane);  // pair captured at this edge
        @(posedge clk);                    // result registered
        @(negedge clk);
        check_outputs(test, e);
    endtask

    task automatic test_reset();
        lane_t la;
        // beq on equal operands guessed not taken, kept out by reset
        la = make_lane(1'b1, 32'h0800, 32'h5, 32'h5, 32'h40, BR_BEQ, 1'b0, 32'h0804, PD_COND);
        lane_a_in <= la;
        lane_b_in <= la;
        repeat (15) begin
            @(negedge clk);
            check_quiet("reset");
        end
        @(posedge clk);
        rst       <= 1'b0;
        lane_a_in <= idle_lane;
        lane_b_in <= idle_lane;
        repeat (2) begin                   // first two cycles out of reset
            @(negedge clk);
            check_quiet("reset_exit");
        end
    endtask

    task automatic test_cond_types();
        br_type_e    ct [6];
        br_type_e    t;
        lane_t       la;
        logic [31:0] r1;
        logic [31:0] r2;
        int          i;
        int          k;
        int          p;
        ct = '{BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU};
        for (i = 0; i < 6; i++) begin
            t = ct[i];
            for (k = 0; k < 5; k++) begin
                r1 = rand_bits(32);
                case (k)
                    0: r2 = r1;                    // equal operands
                    1: r2 = r1 ^ 32'h8000_0000;    // opposite sign and same low bits
                    2: begin
                        r1 = 32'hffff_fff0;        // -16 against 16
                        r2 = 32'h0000_0010;
                    end
                    default: r2 = rand_bits(32);
                endcase
                for (p = 0; p < 2; p++) begin
                    la = make_lane(1'b1, rand_pc(), r1, r2, rand_imm(), t, p[0], '0, PD_COND);
                    la.pd_target = p[0] ? la.pc + la.imm : la.pc + `BR_INSN_BYTES;
                    run_pair($sformatf("cond_%s_%0d_%0d", t.name(), k, p), la, idle_lane);
                end
            end
        end
    endtask

    task automatic test_jumps();
        br_type_e jt [3];
        pd_type_e jp [3];
        br_type_e t;
        lane_t    la;
        int       i;
        jt = '{BR_B, BR_BL, BR_JIRL};
        jp = '{PD_COND, PD_CALL, PD_RET_IND};
        for (i = 0; i < 3; i++) begin
            t  = jt[i];
            la = make_lane(1'b1, rand_pc(), rand_bits(32), rand_bits(32), rand_imm(), t,
                           1'b1, '0, jp[i]);
            la.pd_target = jump_dest(la);                  // correct guess
            run_pair($sformatf("jump_%s_ok", t.name()), la, idle_lane);
            la.pd_target = la.pd_target ^ 32'h0000_0100;   // wrong target
            run_pair($sformatf("jump_%s_bad", t.name()), la, idle_lane);
        end
    endtask

    task automatic test_lane_priority();
        lane_t       la;
        lane_t       lb;
        logic [31:0] r;
        r  = rand_bits(32);
        // a guessed taken on unequal beq and b guessed not taken on unequal bne
        la = make_lane(1'b1, 32'h1000, r, r + 32'd1, 32'h40, BR_BEQ, 1'b1, 32'h1040, PD_COND);
        lb = make_lane(1'b1, 32'h1004, r, r + 32'd1, 32'h80, BR_BNE, 1'b0, 32'h1008, PD_COND);
        run_pair("both_mispredict", la, lb);
        la = make_lane(1'b1, 32'h2000, r, r, 32'h100, BR_B, 1'b1, 32'h2100, PD_COND);
        run_pair("b_wrong_path", la, lb);
        la = make_lane(1'b1, 32'h3000, r, r + 32'd1, 32'h40, BR_BEQ, 1'b0, 32'h3004, PD_COND);
        run_pair("b_redirects", la, lb);
    endtask

    task automatic test_update_select();
        lane_t la;
        lane_t lb;
        la = make_lane(1'b1, 32'h4000, rand_bits(32), rand_bits(32), 32'h0, BR_NONE,
                       1'b0, 32'h4004, PD_NONE);
        lb = make_lane(1'b1, 32'h4004, rand_bits(32), rand_bits(32), 32'hffff_ff00, BR_BLTU,
                       1'b0, 32'h4008, PD_COND);
        run_pair("upd_from_b", la, lb);
        la = make_lane(1'b1, 32'h4100, rand_bits(32), rand_bits(32), 32'h0000_0300, BR_BGE,
                       1'b1, 32'h4400, PD_COND);
        lb = make_lane(1'b1, 32'h4104, 32'h0, 32'h0, 32'h0000_1000, BR_BL,
                       1'b1, 32'h5104, PD_CALL);
        run_pair("upd_from_a", la, lb);
        la.pd_type = PD_NONE;
        lb.pd_type = PD_NONE;
        run_pair("upd_none", la, lb);
    endtask

    task automatic test_stall_hold();
        lane_t       la;
        expect_t     e;
        logic [31:0] r;
        r  = rand_bits(32);
        // bne on unequal operands guessed not taken
        la = make_lane(1'b1, 32'h5000, r, ~r, 32'h200, BR_BNE, 1'b0, 32'h5004, PD_COND);
        e  = expected_outputs(la, idle_lane);
        drive_pair(la, idle_lane);
        @(posedge clk);                    // pair lands in the issue register
        lane_a_in <= idle_lane;
        stall     <= 1'b1;
        repeat (5) begin
            @(negedge clk);
            check_quiet("stall_hold");
        end
        @(posedge clk);
        stall <= 1'b0;
        wait_pulse("stall_hold", 4);
        check_outputs("stall_hold", e);
        repeat (4) begin                   // exactly one pulse
            @(negedge clk);
            check_quiet("stall_after");
        end
    endtask

    task automatic test_flush_behind_redirect();
        lane_t       p1;
        lane_t       p2;
        expect_t     e;
        logic [31:0] r;
        r  = rand_bits(32);
        p1 = make_lane(1'b1, 32'h6000, r, r, 32'h80, BR_BEQ, 1'b0, 32'h6004, PD_COND);
        p2 = make_lane(1'b1, 32'h7000, r, r, 32'h40, BR_BEQ, 1'b0, 32'h7004, PD_COND);
        e  = expected_outputs(p1, idle_lane);
        drive_pair(p1, idle_lane);
        drive_pair(p2, p2);                // wrong path pair right behind
        @(posedge clk);                    // p2 stays on the ports as a second wrong path pair
        @(negedge clk);
        check_outputs("flush_first", e);
        drive_pair(idle_lane, idle_lane);  // pair on the ports here is flushed
        repeat (3) begin
            @(negedge clk);
            check_quiet("flush_wrong_path");
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst       <= 1'b1;
        stall     <= 1'b0;
        lane_a_in <= idle_lane;
        lane_b_in <= idle_lane;
        test_reset();
        test_cond_types();
        test_jumps();
        test_lane_priority();
        test_update_select();
        test_stall_hold();
        test_flush_behind_redirect();
        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== build.f ====
+incdir+src
+incdir+test
src/br_pkg.sv
src/br_lane_if.sv
src/branch_eval.sv
src/branch_resolve.sv
src/ex_issue_reg.sv
src/redirect_reg.sv
src/br_unit_top.sv
test/tb_br_unit.sv

// ==== Makefile ====
# Verilator build and run for the branch unit testbench

VERILATOR ?= verilator
TOP       ?= tb_br_unit
OBJ_DIR   ?= obj_dir
FILELIST  ?= build.f
VFLAGS    ?= --binary --timing -j 0

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(wildcard src/*.sv src/*.svh test/*.sv test/*.svh)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

# exit status of the simulator is the pass or fail result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)
